// File: logic/tl2umi_config.svh
// TileLink to UMI bridge configuration

`ifndef TL2UMI_CONFIG_SVH
`define TL2UMI_CONFIG_SVH

// TileLink channel widths
`define TL_ADDR_W 56
`define TL_DATA_W 64
`define TL_SOURCE_W 5

// UMI host port widths
`define UMI_AW 64
`define UMI_CW 32
`define CHIPID_W 16

// Request and response buffering
`define PKT_FIFO_DEPTH 2

`endif

// File: logic/tl_pkg.sv
// TileLink-UH channel types

`include "tl2umi_config.svh"

package tl_pkg;

    typedef enum logic [2:0] {
        TL_PUT_FULL    = 3'd0,
        TL_PUT_PARTIAL = 3'd1,
        TL_ARITH       = 3'd2,
        TL_LOGIC       = 3'd3,
        TL_GET         = 3'd4
    } tl_a_opcode_e;

    typedef enum logic [2:0] {
        TL_ACCESS_ACK      = 3'd0,
        TL_ACCESS_ACK_DATA = 3'd1
    } tl_d_opcode_e;

    // ArithmeticData params
    localparam logic [2:0] TL_PA_MIN  = 3'd0;
    localparam logic [2:0] TL_PA_MAX  = 3'd1;
    localparam logic [2:0] TL_PA_MINU = 3'd2;
    localparam logic [2:0] TL_PA_MAXU = 3'd3;
    localparam logic [2:0] TL_PA_ADD  = 3'd4;

    // LogicalData params
    localparam logic [2:0] TL_PL_XOR  = 3'd0;
    localparam logic [2:0] TL_PL_OR   = 3'd1;
    localparam logic [2:0] TL_PL_AND  = 3'd2;
    localparam logic [2:0] TL_PL_SWAP = 3'd3;

    typedef struct packed {
        tl_a_opcode_e              opcode;
        logic [2:0]                param;
        logic [2:0]                size;
        logic [`TL_SOURCE_W-1:0]   source;
        logic [`TL_ADDR_W-1:0]     address;
        logic [`TL_DATA_W/8-1:0]   mask;
        logic [`TL_DATA_W-1:0]     data;
    } tl_a_t;

    typedef struct packed {
        tl_d_opcode_e              opcode;
        logic [2:0]                size;
        logic [`TL_SOURCE_W-1:0]   source;
        logic [`TL_DATA_W-1:0]     data;
    } tl_d_t;

endpackage

// File: logic/umi_pkg.sv
// UMI packet types

`include "tl2umi_config.svh"

package umi_pkg;

    typedef enum logic [4:0] {
        UMI_REQ_READ   = 5'd1,
        UMI_RESP_READ  = 5'd2,
        UMI_REQ_WRITE  = 5'd3,
        UMI_RESP_WRITE = 5'd4,
        UMI_REQ_ATOMIC = 5'd9,
        UMI_REQ_ERROR  = 5'd15
    } umi_opcode_e;

    typedef enum logic [7:0] {
        UMI_ATYPE_ADD  = 8'd0,
        UMI_ATYPE_AND  = 8'd1,
        UMI_ATYPE_OR   = 8'd2,
        UMI_ATYPE_XOR  = 8'd3,
        UMI_ATYPE_MAX  = 8'd4,
        UMI_ATYPE_MIN  = 8'd5,
        UMI_ATYPE_MAXU = 8'd6,
        UMI_ATYPE_MINU = 8'd7,
        UMI_ATYPE_SWAP = 8'd8
    } umi_atype_e;

    // Listed from the top bit down, opcode sits at bit 0
    typedef struct packed {
        logic [`UMI_CW-18:0] reserved;
        logic                eom;
        logic [7:0]          len_atype;
        logic [2:0]          size;
        umi_opcode_e         opcode;
    } umi_cmd_t;

    // User bits of the source address, echoed back in the response
    typedef struct packed {
        logic [7:0] first_one;
        logic [7:0] tl_size;
        logic [7:0] tl_source;
    } umi_src_user_t;

    localparam int SRC_USER_LSB = 16;

    typedef struct packed {
        umi_cmd_t              cmd;
        logic [`UMI_AW-1:0]    dstaddr;
        logic [`UMI_AW-1:0]    srcaddr;
        logic [`TL_DATA_W-1:0] data;
    } umi_packet_t;

endpackage

// File: logic/mask_compactor.sv
// Byte mask to maskless compaction

`timescale 1ns/100ps
`include "tl2umi_config.svh"

module mask_compactor (
    input  logic                    check,
    input  logic [`TL_DATA_W/8-1:0] mask,
    input  logic [`TL_DATA_W-1:0]   data,
    output logic [2:0]              first_one,
    output logic [7:0]              len,
    output logic [`TL_DATA_W-1:0]   aligned_data
);

    logic [7:0] ones;

    // Lowest set lane wins
    always_comb begin
        first_one = '0;
        for (int i = `TL_DATA_W/8 - 1; i >= 0; i--) begin
            if (mask[i]) begin
                first_one = 3'(i);
            end
        end
    end

    always_comb begin
        ones = '0;
        for (int i = 0; i < `TL_DATA_W/8; i++) begin
            ones = ones + 8'(mask[i]);
        end
    end

    // UMI length counts bytes minus one
    assign len = ones - 8'd1;

    assign aligned_data = data >> {first_one, 3'b000};

    // A presented beat must enable at least one byte
    always_comb begin
        if (check) begin
            a_mask_nonzero: assert final (mask != '0)
                else $error("zero byte mask on A channel");
        end
    end

endmodule

// File: logic/tl_a_translator.sv
// TileLink A channel to UMI request

`timescale 1ns/100ps
`include "tl2umi_config.svh"

module tl_a_translator (
    input  logic                  clk,
    input  logic                  nreset,
    input  logic [`CHIPID_W-1:0]  chipid,
    input  logic                  tl_a_valid,
    output logic                  tl_a_ready,
    input  tl_pkg::tl_a_t         tl_a,
    output logic                  pkt_valid,
    input  logic                  pkt_ready,
    output umi_pkg::umi_packet_t  pkt,
    input  logic                  txn_done
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ISSUE,
        ST_WAIT
    } state_e;

    state_e                 state;
    umi_pkg::umi_packet_t   pkt_next;
    umi_pkg::umi_src_user_t src_user;
    umi_pkg::umi_atype_e    atype;
    logic                   atype_ok;
    logic                   supported;
    logic                   accept;
    logic [2:0]             first_one;
    logic [7:0]             comp_len;
    logic [`TL_DATA_W-1:0]  comp_data;

    mask_compactor u_compactor (
        .check        (tl_a_valid),
        .mask         (tl_a.mask),
        .data         (tl_a.data),
        .first_one    (first_one),
        .len          (comp_len),
        .aligned_data (comp_data)
    );

    // Single outstanding transaction
    assign tl_a_ready = (state == ST_IDLE);
    assign pkt_valid  = (state == ST_ISSUE);
    assign accept     = tl_a_valid && tl_a_ready;

    always_comb begin
        atype    = umi_pkg::UMI_ATYPE_ADD;
        atype_ok = 1'b1;
        if (tl_a.opcode == tl_pkg::TL_ARITH) begin
            case (tl_a.param)
                tl_pkg::TL_PA_MIN:  atype = umi_pkg::UMI_ATYPE_MIN;
                tl_pkg::TL_PA_MAX:  atype = umi_pkg::UMI_ATYPE_MAX;
                tl_pkg::TL_PA_MINU: atype = umi_pkg::UMI_ATYPE_MINU;
                tl_pkg::TL_PA_MAXU: atype = umi_pkg::UMI_ATYPE_MAXU;
                tl_pkg::TL_PA_ADD:  atype = umi_pkg::UMI_ATYPE_ADD;
                default:            atype_ok = 1'b0;
            endcase
        end else begin
            case (tl_a.param)
                tl_pkg::TL_PL_XOR:  atype = umi_pkg::UMI_ATYPE_XOR;
                tl_pkg::TL_PL_OR:   atype = umi_pkg::UMI_ATYPE_OR;
                tl_pkg::TL_PL_AND:  atype = umi_pkg::UMI_ATYPE_AND;
                tl_pkg::TL_PL_SWAP: atype = umi_pkg::UMI_ATYPE_SWAP;
                default:            atype_ok = 1'b0;
            endcase
        end
    end

    always_comb begin
        src_user.first_one = 8'(first_one);
        src_user.tl_size   = 8'(tl_a.size);
        src_user.tl_source = 8'(tl_a.source);

        pkt_next         = '0;
        pkt_next.cmd.eom = 1'b1;
        pkt_next.dstaddr = `UMI_AW'({tl_a.address[`TL_ADDR_W-1:3], first_one});
        pkt_next.srcaddr = {{(24 - `CHIPID_W){1'b0}}, chipid, src_user,
                            {umi_pkg::SRC_USER_LSB{1'b0}}};
        supported = 1'b1;
        case (tl_a.opcode)
            tl_pkg::TL_GET: begin
                pkt_next.cmd.opcode    = umi_pkg::UMI_REQ_READ;
                pkt_next.cmd.len_atype = (8'd1 << tl_a.size) - 8'd1;
            end
            tl_pkg::TL_PUT_FULL, tl_pkg::TL_PUT_PARTIAL: begin
                pkt_next.cmd.opcode    = umi_pkg::UMI_REQ_WRITE;
                pkt_next.cmd.len_atype = comp_len;
                pkt_next.data          = comp_data;
            end
            tl_pkg::TL_ARITH, tl_pkg::TL_LOGIC: begin
                pkt_next.cmd.opcode    = atype_ok ? umi_pkg::UMI_REQ_ATOMIC
                                                  : umi_pkg::UMI_REQ_ERROR;
                pkt_next.cmd.size      = tl_a.size;
                pkt_next.cmd.len_atype = atype;
                pkt_next.data          = comp_data;
            end
            default: supported = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!nreset) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    // Unknown opcodes are taken and dropped
                    if (accept && supported) begin
                        state <= ST_ISSUE;
                    end
                end
                ST_ISSUE: begin
                    if (pkt_ready) begin
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (txn_done) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pkt <= pkt_next;
        end
    end

    a_put_single_beat: assert property (@(posedge clk) disable iff (!nreset)
        accept && (tl_a.opcode inside {tl_pkg::TL_PUT_FULL, tl_pkg::TL_PUT_PARTIAL})
        |-> tl_a.size <= 3'd3);

    a_pkt_hold: assert property (@(posedge clk) disable iff (!nreset)
        pkt_valid && !pkt_ready |=> pkt_valid && $stable(pkt));

endmodule

// File: logic/packet_fifo.sv
// Small synchronous packet FIFO

`timescale 1ns/100ps
`include "tl2umi_config.svh"

module packet_fifo #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic nreset,
    input  logic in_valid,
    output logic in_ready,
    input  T     in_data,
    output logic out_valid,
    input  logic out_ready,
    output T     out_data
);

    localparam int DEPTH = `PKT_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign in_ready  = (count != CNT_W'(DEPTH));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!nreset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!nreset)
        count <= CNT_W'(DEPTH));

endmodule

// File: logic/tl_d_responder.sv
// UMI response to TileLink D channel

`timescale 1ns/100ps
`include "tl2umi_config.svh"

module tl_d_responder (
    input  logic                 clk,
    input  logic                 nreset,
    input  logic                 resp_valid,
    output logic                 resp_ready,
    input  umi_pkg::umi_packet_t resp,
    output logic                 tl_d_valid,
    input  logic                 tl_d_ready,
    output tl_pkg::tl_d_t        tl_d,
    output logic                 txn_done
);

    umi_pkg::umi_src_user_t user;
    logic                   pop;

    // Size, source and lane offset ride back in the destination address
    assign user = resp.dstaddr[umi_pkg::SRC_USER_LSB +: $bits(umi_pkg::umi_src_user_t)];

    assign resp_ready = !tl_d_valid;
    assign pop        = resp_valid && resp_ready;
    assign txn_done   = tl_d_valid && tl_d_ready;

    always_ff @(posedge clk) begin
        if (!nreset) begin
            tl_d_valid <= 1'b0;
        end else if (pop) begin
            tl_d_valid <= 1'b1;
        end else if (txn_done) begin
            tl_d_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            tl_d.size   <= user.tl_size[2:0];
            tl_d.source <= user.tl_source[`TL_SOURCE_W-1:0];
            if (resp.cmd.opcode == umi_pkg::UMI_RESP_READ) begin
                tl_d.opcode <= tl_pkg::TL_ACCESS_ACK_DATA;
                // Back into byte lane position
                tl_d.data   <= resp.data << {user.first_one[2:0], 3'b000};
            end else begin
                tl_d.opcode <= tl_pkg::TL_ACCESS_ACK;
                tl_d.data   <= '0;
            end
        end
    end

    a_resp_opcode: assert property (@(posedge clk) disable iff (!nreset)
        pop |-> resp.cmd.opcode inside {umi_pkg::UMI_RESP_READ, umi_pkg::UMI_RESP_WRITE});

endmodule

// File: logic/tl2umi_bridge.sv
// TileLink-UH to UMI host bridge

`timescale 1ns/100ps
`include "tl2umi_config.svh"

module tl2umi_bridge (
    input  logic                  clk,
    input  logic                  nreset,
    input  logic [`CHIPID_W-1:0]  chipid,
    input  logic                  tl_a_valid,
    output logic                  tl_a_ready,
    input  tl_pkg::tl_a_t         tl_a,
    output logic                  tl_d_valid,
    input  logic                  tl_d_ready,
    output tl_pkg::tl_d_t         tl_d,
    output logic                  umi_req_valid,
    input  logic                  umi_req_ready,
    output umi_pkg::umi_packet_t  umi_req,
    input  logic                  umi_resp_valid,
    output logic                  umi_resp_ready,
    input  umi_pkg::umi_packet_t  umi_resp
);

    logic                 req_pkt_valid;
    logic                 req_pkt_ready;
    umi_pkg::umi_packet_t req_pkt;
    logic                 resp_pkt_valid;
    logic                 resp_pkt_ready;
    umi_pkg::umi_packet_t resp_pkt;
    logic                 txn_done;

    tl_a_translator u_translator (
        .clk        (clk),
        .nreset     (nreset),
        .chipid     (chipid),
        .tl_a_valid (tl_a_valid),
        .tl_a_ready (tl_a_ready),
        .tl_a       (tl_a),
        .pkt_valid  (req_pkt_valid),
        .pkt_ready  (req_pkt_ready),
        .pkt        (req_pkt),
        .txn_done   (txn_done)
    );

    packet_fifo #(.T(umi_pkg::umi_packet_t)) u_req_fifo (
        .clk       (clk),
        .nreset    (nreset),
        .in_valid  (req_pkt_valid),
        .in_ready  (req_pkt_ready),
        .in_data   (req_pkt),
        .out_valid (umi_req_valid),
        .out_ready (umi_req_ready),
        .out_data  (umi_req)
    );

    packet_fifo #(.T(umi_pkg::umi_packet_t)) u_resp_fifo (
        .clk       (clk),
        .nreset    (nreset),
        .in_valid  (umi_resp_valid),
        .in_ready  (umi_resp_ready),
        .in_data   (umi_resp),
        .out_valid (resp_pkt_valid),
        .out_ready (resp_pkt_ready),
        .out_data  (resp_pkt)
    );

    tl_d_responder u_responder (
        .clk        (clk),
        .nreset     (nreset),
        .resp_valid (resp_pkt_valid),
        .resp_ready (resp_pkt_ready),
        .resp       (resp_pkt),
        .tl_d_valid (tl_d_valid),
        .tl_d_ready (tl_d_ready),
        .tl_d       (tl_d),
        .txn_done   (txn_done)
    );

endmodule

// File: test/tb_tl2umi.sv
// TileLink to UMI bridge testbench

`timescale 1ns/100ps
`include "tl2umi_config.svh"

module tb_tl2umi;

    localparam int NUM_ROWS       = 17;
    localparam int RESET_CYCLES   = 10;
    localparam int CYCLES_PER_ROW = 200;
    localparam logic [`CHIPID_W-1:0] CHIP_ID = 16'h5a3c;

    // Each row holds an A beat, expected request, device response and expected D beat
    typedef struct packed {
        tl_pkg::tl_a_t          a;
        umi_pkg::umi_opcode_e   req_op;
        logic [2:0]             req_size;
        logic [7:0]             req_len;
        logic [`UMI_AW-1:0]     req_dst;
        logic [`TL_DATA_W-1:0]  req_data;
        umi_pkg::umi_opcode_e   resp_op;
        logic [`TL_DATA_W-1:0]  resp_data;
        tl_pkg::tl_d_opcode_e   d_op;
        logic [`TL_DATA_W-1:0]  d_data;
    } row_t;

    logic                 clk;
    logic                 nreset;
    logic [`CHIPID_W-1:0] chipid;
    logic                 tl_a_valid;
    logic                 tl_a_ready;
    tl_pkg::tl_a_t        tl_a;
    logic                 tl_d_valid;
    logic                 tl_d_ready;
    tl_pkg::tl_d_t        tl_d;
    logic                 umi_req_valid;
    logic                 umi_req_ready;
    umi_pkg::umi_packet_t umi_req;
    logic                 umi_resp_valid;
    logic                 umi_resp_ready;
    umi_pkg::umi_packet_t umi_resp;

    row_t                 rows [NUM_ROWS];
    logic [31:0]          rng_state;

    // Monitor state
    logic                 req_wait;
    logic                 d_wait;
    logic                 outstanding;
    logic                 req_seen;
    umi_pkg::umi_packet_t req_hold;
    tl_pkg::tl_d_t        d_hold;

    tl2umi_bridge dut (
        .clk            (clk),
        .nreset         (nreset),
        .chipid         (chipid),
        .tl_a_valid     (tl_a_valid),
        .tl_a_ready     (tl_a_ready),
        .tl_a           (tl_a),
        .tl_d_valid     (tl_d_valid),
        .tl_d_ready     (tl_d_ready),
        .tl_d           (tl_d),
        .umi_req_valid  (umi_req_valid),
        .umi_req_ready  (umi_req_ready),
        .umi_req        (umi_req),
        .umi_resp_valid (umi_resp_valid),
        .umi_resp_ready (umi_resp_ready),
        .umi_resp       (umi_resp)
    );

    always #4 clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input string name, input logic [255:0] actual,
                         input logic [255:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("ERROR %s: got 0x%0h, expected 0x%0h", name, actual, expected));
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Ready three times out of four
    function automatic logic draw_ready();
        rng_state = xorshift32(rng_state);
        return rng_state[1:0] != 2'b00;
    endfunction

    function automatic int draw_delay();
        rng_state = xorshift32(rng_state);
        return int'(rng_state[2:0]);
    endfunction

    // Command word from the low end is opcode, size, len or atype, then eom
    function automatic logic [`UMI_CW-1:0] expected_cmd(input row_t r);
        return {15'h0000, 1'b1, r.req_len, r.req_size, r.req_op};
    endfunction

    // Chip id, then first-one offset, TileLink size and source, then 16 zero bits
    function automatic logic [`UMI_AW-1:0] expected_srcaddr(input row_t r);
        logic [7:0] first_one;
        first_one = {5'b00000, r.req_dst[2:0]};
        return {8'h00, CHIP_ID, first_one, {5'b00000, r.a.size}, {3'b000, r.a.source},
                16'h0000};
    endfunction

    function automatic row_t make_row(
        input tl_pkg::tl_a_opcode_e    op,
        input logic [2:0]              param,
        input logic [2:0]              size,
        input logic [`TL_SOURCE_W-1:0] source,
        input logic [`TL_ADDR_W-1:0]   address,
        input logic [7:0]              mask,
        input logic [`TL_DATA_W-1:0]   data,
        input umi_pkg::umi_opcode_e    req_op,
        input logic [2:0]              req_size,
        input logic [7:0]              req_len,
        input logic [`UMI_AW-1:0]      req_dst,
        input logic [`TL_DATA_W-1:0]   req_data,
        input umi_pkg::umi_opcode_e    resp_op,
        input logic [`TL_DATA_W-1:0]   resp_data,
        input tl_pkg::tl_d_opcode_e    d_op,
        input logic [`TL_DATA_W-1:0]   d_data
    );
        row_t r;
        r           = '0;
        r.a.opcode  = op;
        r.a.param   = param;
        r.a.size    = size;
        r.a.source  = source;
        r.a.address = address;
        r.a.mask    = mask;
        r.a.data    = data;
        r.req_op    = req_op;
        r.req_size  = req_size;
        r.req_len   = req_len;
        r.req_dst   = req_dst;
        r.req_data  = req_data;
        r.resp_op   = resp_op;
        r.resp_data = resp_data;
        r.d_op      = d_op;
        r.d_data    = d_data;
        return r;
    endfunction

    task automatic load_table();
        // Gets, read data comes back shifted into lane position
        rows[0] = make_row(tl_pkg::TL_GET, 3'd0, 3'd3, 5'd3, 56'h12_3456_7000, 8'hff, 64'h0,
            umi_pkg::UMI_REQ_READ, 3'd0, 8'd7, 64'h12_3456_7000, 64'h0,
            umi_pkg::UMI_RESP_READ, 64'h0123_4567_89ab_cdef,
            tl_pkg::TL_ACCESS_ACK_DATA, 64'h0123_4567_89ab_cdef);
        rows[1] = make_row(tl_pkg::TL_GET, 3'd0, 3'd2, 5'd17, 56'h20_0004, 8'hf0, 64'h0,
            umi_pkg::UMI_REQ_READ, 3'd0, 8'd3, 64'h20_0004, 64'h0,
            umi_pkg::UMI_RESP_READ, 64'h0000_0000_89ab_cdef,
            tl_pkg::TL_ACCESS_ACK_DATA, 64'h89ab_cdef_0000_0000);
        rows[2] = make_row(tl_pkg::TL_GET, 3'd0, 3'd0, 5'd31, 56'haaaa_0003, 8'h08, 64'h0,
            umi_pkg::UMI_REQ_READ, 3'd0, 8'd0, 64'haaaa_0003, 64'h0,
            umi_pkg::UMI_RESP_READ, 64'h0000_0000_0000_00a5,
            tl_pkg::TL_ACCESS_ACK_DATA, 64'h0000_0000_a500_0000);
        // Puts, full and sparse masks
        rows[3] = make_row(tl_pkg::TL_PUT_FULL, 3'd0, 3'd3, 5'd1, 56'h1000, 8'hff,
            64'hdead_beef_cafe_f00d,
            umi_pkg::UMI_REQ_WRITE, 3'd0, 8'd7, 64'h1000, 64'hdead_beef_cafe_f00d,
            umi_pkg::UMI_RESP_WRITE, 64'h0, tl_pkg::TL_ACCESS_ACK, 64'h0);
        rows[4] = make_row(tl_pkg::TL_PUT_PARTIAL, 3'd0, 3'd3, 5'd2, 56'h2000, 8'h34,
            64'h1122_3344_5566_7788,
            umi_pkg::UMI_REQ_WRITE, 3'd0, 8'd2, 64'h2002, 64'h0000_1122_3344_5566,
            umi_pkg::UMI_RESP_WRITE, 64'h0, tl_pkg::TL_ACCESS_ACK, 64'h0);
        rows[5] = make_row(tl_pkg::TL_PUT_PARTIAL, 3'd0, 3'd0, 5'd9, 56'h3007, 8'h80,
            64'hab00_0000_0000_0000,
            umi_pkg::UMI_REQ_WRITE, 3'd0, 8'd0, 64'h3007, 64'h0000_0000_0000_00ab,
            umi_pkg::UMI_RESP_WRITE, 64'h0, tl_pkg::TL_ACCESS_ACK, 64'h0);
        // Arithmetic atomics
        rows[6] = make_row(tl_pkg::TL_ARITH, tl_pkg::TL_PA_MIN, 3'd3, 5'd4, 56'h5000, 8'hff,
            64'h10, umi_pkg::UMI_REQ_ATOMIC, 3'd3, 8'd5, 64'h5000, 64'h10,
            umi_pkg::UMI_RESP_READ, 64'h42, tl_pkg::TL_ACCESS_ACK_DATA, 64'h42);
        rows[7] = make_row(tl_pkg::TL_ARITH, tl_pkg::TL_PA_MAX, 3'd2, 5'd6, 56'h5008, 8'h0f,
            64'h7fff_ffff, umi_pkg::UMI_REQ_ATOMIC, 3'd2, 8'd4, 64'h5008, 64'h7fff_ffff,
            umi_pkg::UMI_RESP_READ, 64'h1234, tl_pkg::TL_ACCESS_ACK_DATA, 64'h1234);
        rows[8] = make_row(tl_pkg::TL_ARITH, tl_pkg::TL_PA_MINU, 3'd3, 5'd7, 56'h5010, 8'hff,
            64'h3, umi_pkg::UMI_REQ_ATOMIC, 3'd3, 8'd7, 64'h5010, 64'h3,
            umi_pkg::UMI_RESP_READ, 64'h9, tl_pkg::TL_ACCESS_ACK_DATA, 64'h9);
        rows[9] = make_row(tl_pkg::TL_ARITH, tl_pkg::TL_PA_MAXU, 3'd3, 5'd10, 56'h5018, 8'hff,
            64'hffff_0000_0000_0000, umi_pkg::UMI_REQ_ATOMIC, 3'd3, 8'd6, 64'h5018,
            64'hffff_0000_0000_0000,
            umi_pkg::UMI_RESP_READ, 64'h1, tl_pkg::TL_ACCESS_ACK_DATA, 64'h1);
        rows[10] = make_row(tl_pkg::TL_ARITH, tl_pkg::TL_PA_ADD, 3'd2, 5'd11, 56'h5104, 8'hf0,
            64'h0000_0005_0000_0000, umi_pkg::UMI_REQ_ATOMIC, 3'd2, 8'd0, 64'h5104, 64'h5,
            umi_pkg::UMI_RESP_READ, 64'h7,
            tl_pkg::TL_ACCESS_ACK_DATA, 64'h0000_0007_0000_0000);
        rows[11] = make_row(tl_pkg::TL_ARITH, 3'd5, 3'd3, 5'd12, 56'h5020, 8'hff,
            64'h1, umi_pkg::UMI_REQ_ERROR, 3'd3, 8'd0, 64'h5020, 64'h1,
            umi_pkg::UMI_RESP_WRITE, 64'h0, tl_pkg::TL_ACCESS_ACK, 64'h0);
        // Logical atomics
        rows[12] = make_row(tl_pkg::TL_LOGIC, tl_pkg::TL_PL_XOR, 3'd3, 5'd13, 56'h6000, 8'hff,
            64'h00ff_00ff_00ff_00ff, umi_pkg::UMI_REQ_ATOMIC, 3'd3, 8'd3, 64'h6000,
            64'h00ff_00ff_00ff_00ff, umi_pkg::UMI_RESP_READ, 64'hff00_ff00_ff00_ff00,
            tl_pkg::TL_ACCESS_ACK_DATA, 64'hff00_ff00_ff00_ff00);
        rows[13] = make_row(tl_pkg::TL_LOGIC, tl_pkg::TL_PL_OR, 3'd3, 5'd14, 56'h6008, 8'hff,
            64'h8, umi_pkg::UMI_REQ_ATOMIC, 3'd3, 8'd2, 64'h6008, 64'h8,
            umi_pkg::UMI_RESP_READ, 64'h80, tl_pkg::TL_ACCESS_ACK_DATA, 64'h80);
        rows[14] = make_row(tl_pkg::TL_LOGIC, tl_pkg::TL_PL_AND, 3'd1, 5'd15, 56'h6012, 8'h0c,
            64'h0000_0000_abcd_0000, umi_pkg::UMI_REQ_ATOMIC, 3'd1, 8'd1, 64'h6012, 64'habcd,
            umi_pkg::UMI_RESP_READ, 64'hcd,
            tl_pkg::TL_ACCESS_ACK_DATA, 64'h0000_0000_00cd_0000);
        rows[15] = make_row(tl_pkg::TL_LOGIC, tl_pkg::TL_PL_SWAP, 3'd3, 5'd16, 56'h6018, 8'hff,
            64'h5555, umi_pkg::UMI_REQ_ATOMIC, 3'd3, 8'd8, 64'h6018, 64'h5555,
            umi_pkg::UMI_RESP_READ, 64'haaaa, tl_pkg::TL_ACCESS_ACK_DATA, 64'haaaa);
        rows[16] = make_row(tl_pkg::TL_LOGIC, 3'd4, 3'd3, 5'd0, 56'h6020, 8'hff,
            64'h2, umi_pkg::UMI_REQ_ERROR, 3'd3, 8'd0, 64'h6020, 64'h2,
            umi_pkg::UMI_RESP_WRITE, 64'h0, tl_pkg::TL_ACCESS_ACK, 64'h0);
    endtask

    // Host sends the A beat, device answers, host takes the D beat
    task automatic run_row(input row_t r);
        umi_pkg::umi_packet_t req;
        umi_pkg::umi_packet_t resp;
        tl_pkg::tl_d_t        d;
        logic                 done;
        int                   delay;

        @(negedge clk);
        tl_a       = r.a;
        tl_a_valid = 1'b1;
        @(posedge clk);
        while (!tl_a_ready) begin
            @(posedge clk);
        end
        @(negedge clk);
        tl_a_valid = 1'b0;

        done = 1'b0;
        while (!done) begin
            umi_req_ready = draw_ready();
            @(posedge clk);
            done = umi_req_valid && umi_req_ready;
            req  = umi_req;
            @(negedge clk);
        end
        umi_req_ready = 1'b0;
        check("umi_req.cmd", req.cmd, expected_cmd(r));
        check("umi_req.dstaddr", req.dstaddr, r.req_dst);
        check("umi_req.srcaddr", req.srcaddr, expected_srcaddr(r));
        check("umi_req.data", req.data, r.req_data);

        // Response goes back to the request source address
        delay = draw_delay();
        repeat (delay) @(negedge clk);
        resp             = '0;
        resp.cmd.opcode  = r.resp_op;
        resp.cmd.eom     = 1'b1;
        resp.dstaddr     = req.srcaddr;
        resp.data        = r.resp_data;
        umi_resp         = resp;
        umi_resp_valid   = 1'b1;
        @(posedge clk);
        while (!umi_resp_ready) begin
            @(posedge clk);
        end
        @(negedge clk);
        umi_resp_valid = 1'b0;

        done = 1'b0;
        while (!done) begin
            tl_d_ready = draw_ready();
            @(posedge clk);
            done = tl_d_valid && tl_d_ready;
            d    = tl_d;
            @(negedge clk);
        end
        tl_d_ready = 1'b0;
        check("tl_d.opcode", d.opcode, r.d_op);
        check("tl_d.size", d.size, r.a.size);
        check("tl_d.source", d.source, r.a.source);
        check("tl_d.data", d.data, r.d_data);
    endtask

    // Hold checks under back-pressure and the one-outstanding rule
    always @(posedge clk) begin
        if (!nreset) begin
            req_wait    = 1'b0;
            d_wait      = 1'b0;
            outstanding = 1'b0;
            req_seen    = 1'b0;
        end else begin
            if (req_wait) begin
                check("umi_req_valid", umi_req_valid, 1'b1);
                check("umi_req", umi_req, req_hold);
            end
            if (d_wait) begin
                check("tl_d_valid", tl_d_valid, 1'b1);
                check("tl_d", tl_d, d_hold);
            end
            if (outstanding) begin
                check("tl_a_ready", tl_a_ready, 1'b0);
            end
            if (umi_req_valid && (!outstanding || req_seen)) begin
                abort_run("A UMI request appeared outside the single outstanding A beat");
            end
            if (umi_req_valid && umi_req_ready) begin
                req_seen = 1'b1;
            end
            if (tl_d_valid && tl_d_ready) begin
                outstanding = 1'b0;
            end
            if (tl_a_valid && tl_a_ready) begin
                outstanding = 1'b1;
                req_seen    = 1'b0;
            end
            req_wait = umi_req_valid && !umi_req_ready;
            req_hold = umi_req;
            d_wait   = tl_d_valid && !tl_d_ready;
            d_hold   = tl_d;
        end
    end

    initial begin
        repeat (RESET_CYCLES + NUM_ROWS * CYCLES_PER_ROW) @(posedge clk);
        abort_run("Timeout: the bridge did not finish all table rows in the allowed cycles");
    end

    initial begin
        clk            = 1'b0;
        nreset         = 1'b0;
        chipid         = CHIP_ID;
        tl_a_valid     = 1'b0;
        tl_a           = '0;
        tl_d_ready     = 1'b0;
        umi_req_ready  = 1'b0;
        umi_resp_valid = 1'b0;
        umi_resp       = '0;
        rng_state      = 32'hd0d895fd;
        load_table();

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        nreset = 1'b1;
        @(negedge clk);
        check("tl_a_ready", tl_a_ready, 1'b1);
        check("umi_resp_ready", umi_resp_ready, 1'b1);
        check("tl_d_valid", tl_d_valid, 1'b0);
        check("umi_req_valid", umi_req_valid, 1'b0);

        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(rows[i]);
        end

        repeat (2) @(negedge clk);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: src.f
+incdir+logic
logic/tl_pkg.sv
logic/umi_pkg.sv
logic/mask_compactor.sv
logic/tl_a_translator.sv
logic/packet_fifo.sv
logic/tl_d_responder.sv
logic/tl2umi_bridge.sv
test/tb_tl2umi.sv

// File: Bender.yml
package:
  name: tl2umi_bridge

export_include_dirs:
  - logic

sources:
  - files:
      - logic/tl_pkg.sv
      - logic/umi_pkg.sv
      - logic/mask_compactor.sv
      - logic/tl_a_translator.sv
      - logic/packet_fifo.sv
      - logic/tl_d_responder.sv
      - logic/tl2umi_bridge.sv
  - target: test
    files:
      - test/tb_tl2umi.sv
